// File: common/rasterPkg.sv
package rasterPkg;

    ////////////////////////////////////////////////////////////
    // Stream and parameter widths
    ////////////////////////////////////////////////////////////
    localparam int CMD_STREAM_WIDTH = 16;
    localparam int TRIANGLE_WORDS = 12;

    typedef logic [CMD_STREAM_WIDTH-1:0] cmdWord_t;
    typedef logic [7:0] coord_t;
    typedef logic signed [15:0] edge_t;
    // RGB565
    typedef logic [15:0] color_t;

    // Position of a parameter word inside a triangle load
    typedef logic [$clog2(TRIANGLE_WORDS)-1:0] wordIdx_t;
    localparam wordIdx_t LAST_WORD_IDX = wordIdx_t'(TRIANGLE_WORDS - 1);

    // Upper nibble of a header word
    typedef enum logic [3:0] {
        OP_NOP      = 4'd0,
        OP_TRIANGLE = 4'd1,
        OP_CLEAR    = 4'd2,
        OP_COMMIT   = 4'd3
    } opcode_t;

    ////////////////////////////////////////////////////////////
    // Packed structs
    ////////////////////////////////////////////////////////////
    // x is the upper byte of a parameter word
    typedef struct packed {
        coord_t x;
        coord_t y;
    } screenPos_t;

    // Word 0 of the load lands in the MSBs
    typedef struct packed {
        screenPos_t bbStart;
        screenPos_t bbEnd;
        edge_t      w0, w1, w2;
        edge_t      w0IncX, w1IncX, w2IncX;
        edge_t      w0IncY, w1IncY, w2IncY;
        color_t     staticColor;
    } triangleParams_t;

    typedef struct packed {
        screenPos_t pos;
        color_t     color;
    } fragment_t;

    typedef struct packed {
        cmdWord_t data;
        logic     last;
    } streamBeat_t;

endpackage

// File: verilog/RegisterBank.sv
`timescale 1ns/1ps

module RegisterBank (
    input  logic                       aclk,
    input  logic                       rst,
    input  logic                       paramValid,
    output logic                       paramReady,
    input  rasterPkg::streamBeat_t     paramBeat,
    output rasterPkg::triangleParams_t params,
    output logic                       bankFull
);

    localparam int WORD_WIDTH = $bits(rasterPkg::cmdWord_t);

    rasterPkg::wordIdx_t        wordIdx;
    rasterPkg::triangleParams_t staging;
    rasterPkg::triangleParams_t stagingNext;
    logic                       wordFire;

    // Bank never stalls the parser
    assign paramReady = 1'b1;
    assign wordFire   = paramValid && paramReady;

    // Slot the incoming word by index, word 0 at the top
    always_comb begin
        stagingNext = staging;
        stagingNext[(rasterPkg::TRIANGLE_WORDS - 1 - wordIdx) * WORD_WIDTH +: WORD_WIDTH] =
            paramBeat.data;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            wordIdx  <= '0;
            bankFull <= 1'b0;
        end else begin
            bankFull <= wordFire && paramBeat.last;
            if (wordFire) begin
                wordIdx <= paramBeat.last ? '0 : wordIdx + 1'b1;
            end
        end
    end

    // Active triangle only swaps once the whole set is in
    always_ff @(posedge aclk) begin
        if (wordFire) begin
            staging <= stagingNext;
            if (paramBeat.last) begin
                params <= stagingNext;
            end
        end
    end

    assert property (@(posedge aclk) disable iff (rst)
        wordFire |-> (paramBeat.last == (wordIdx == rasterPkg::LAST_WORD_IDX)))
        else $error("Parameter stream last out of step with word index");

endmodule

// File: commandParser/CommandParser.sv
`timescale 1ns/1ps

module CommandParser (
    input  logic                   aclk,
    input  logic                   rst,

    input  logic                   cmdValid,
    output logic                   cmdReady,
    input  rasterPkg::streamBeat_t cmdBeat,

    output logic                   paramValid,
    input  logic                   paramReady,
    output rasterPkg::streamBeat_t paramBeat,
    input  logic                   bankFull,

    output logic                   startRendering,
    input  logic                   rasterizerRunning,

    output logic                   clearStart,
    output rasterPkg::color_t      clearColor,
    output logic                   commitStart,
    input  logic                   fbBusy
);

    typedef enum logic [1:0] {
        IDLE,
        PARAMS,
        CLEAR_COLOR,
        WAIT_BANK
    } parserState_t;

    parserState_t        state;
    rasterPkg::wordIdx_t payloadCnt;
    rasterPkg::opcode_t  opcode;
    logic                cmdFire;

    // Stall while a block works or a start pulse is on its way out
    assign cmdReady = (state != WAIT_BANK) && !rasterizerRunning && !fbBusy
                      && !startRendering && !clearStart && !commitStart
                      && (!paramValid || paramReady);
    assign cmdFire  = cmdValid && cmdReady;
    assign opcode   = rasterPkg::opcode_t'(cmdBeat.data[rasterPkg::CMD_STREAM_WIDTH-1 -: 4]);

    ////////////////////////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (rst) begin
            state          <= IDLE;
            payloadCnt     <= '0;
            paramValid     <= 1'b0;
            startRendering <= 1'b0;
            clearStart     <= 1'b0;
            commitStart    <= 1'b0;
        end else begin
            startRendering <= 1'b0;
            clearStart     <= 1'b0;
            commitStart    <= 1'b0;
            if (paramReady) begin
                paramValid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    payloadCnt <= '0;
                    if (cmdFire) begin
                        case (opcode)
                            rasterPkg::OP_TRIANGLE: state <= PARAMS;
                            rasterPkg::OP_CLEAR:    state <= CLEAR_COLOR;
                            rasterPkg::OP_COMMIT:   commitStart <= 1'b1;
                            default:                state <= IDLE; // NOP and unknown
                        endcase
                    end
                end
                PARAMS: begin
                    if (cmdFire) begin
                        paramValid <= 1'b1;
                        payloadCnt <= payloadCnt + 1'b1;
                        if (payloadCnt == rasterPkg::LAST_WORD_IDX) begin
                            state <= WAIT_BANK;
                        end
                    end
                end
                CLEAR_COLOR: begin
                    if (cmdFire) begin
                        clearStart <= 1'b1;
                        state      <= IDLE;
                    end
                end
                WAIT_BANK: begin
                    if (bankFull) begin
                        startRendering <= 1'b1;
                        state          <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge aclk) begin
        if (cmdFire && state == PARAMS) begin
            paramBeat.data <= cmdBeat.data;
            paramBeat.last <= (payloadCnt == rasterPkg::LAST_WORD_IDX);
        end
        if (cmdFire && state == CLEAR_COLOR) begin
            clearColor <= cmdBeat.data;
        end
    end

    // A new triangle must never restart a running walk
    assert property (@(posedge aclk) disable iff (rst)
        startRendering |-> !rasterizerRunning)
        else $error("startRendering while rasterizer is running");

endmodule

// File: rasterizer/Rasterizer.sv
`timescale 1ns/1ps

module Rasterizer #(
    parameter int X_RESOLUTION = 16,
    parameter int Y_RESOLUTION = 16
) (
    input  logic                       aclk,
    input  logic                       rst,
    input  logic                       startRendering,
    output logic                       rasterizerRunning,
    input  rasterPkg::triangleParams_t params,
    output logic                       fragValid,
    output rasterPkg::fragment_t       frag
);

    rasterPkg::screenPos_t pos;
    rasterPkg::edge_t      w [3];
    rasterPkg::edge_t      rowW [3];
    rasterPkg::edge_t      wInit [3];
    rasterPkg::edge_t      incX [3];
    rasterPkg::edge_t      incY [3];
    logic                  lastCol;
    logic                  lastRow;
    logic                  covered;

    assign wInit = '{params.w0, params.w1, params.w2};
    assign incX  = '{params.w0IncX, params.w1IncX, params.w2IncX};
    assign incY  = '{params.w0IncY, params.w1IncY, params.w2IncY};

    assign lastCol = (pos.x == params.bbEnd.x);
    assign lastRow = (pos.y == params.bbEnd.y);

    // Inside when no edge function has gone negative
    assign covered = !w[0][$high(w[0])] && !w[1][$high(w[1])] && !w[2][$high(w[2])];

    assign fragValid  = rasterizerRunning && covered;
    assign frag.pos   = pos;
    assign frag.color = params.staticColor;

    always_ff @(posedge aclk) begin
        if (rst) begin
            rasterizerRunning <= 1'b0;
        end else if (startRendering) begin
            rasterizerRunning <= 1'b1;
        end else if (rasterizerRunning && lastCol && lastRow) begin
            rasterizerRunning <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Bounding box walk, one pixel per cycle
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (startRendering) begin
            pos  <= params.bbStart;
            w    <= wInit;
            rowW <= wInit;
        end else if (rasterizerRunning) begin
            if (!lastCol) begin
                pos.x <= pos.x + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    w[i] <= w[i] + incX[i];
                end
            end else begin
                // Back to the left edge of the next row
                pos.x <= params.bbStart.x;
                pos.y <= pos.y + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    rowW[i] <= rowW[i] + incY[i];
                    w[i]    <= rowW[i] + incY[i];
                end
            end
        end
    end

    // Bounding box from the host has to fit the screen
    assert property (@(posedge aclk) disable iff (rst)
        fragValid |-> (frag.pos.x < X_RESOLUTION) && (frag.pos.y < Y_RESOLUTION))
        else $error("Fragment outside of screen");

endmodule

// File: frameBuffer/FrameBuffer.sv
`timescale 1ns/1ps

module FrameBuffer #(
    parameter int X_RESOLUTION = 16,
    parameter int Y_RESOLUTION = 16
) (
    input  logic                   aclk,
    input  logic                   rst,

    input  logic                   fragValid,
    input  rasterPkg::fragment_t   frag,

    input  logic                   clearStart,
    input  rasterPkg::color_t      clearColor,
    input  logic                   commitStart,
    output logic                   fbBusy,

    output logic                   fbValid,
    input  logic                   fbReady,
    output rasterPkg::streamBeat_t fbBeat
);

    localparam int PIXELS = X_RESOLUTION * Y_RESOLUTION;
    localparam int INDEX_WIDTH = $clog2(PIXELS);

    typedef logic [INDEX_WIDTH-1:0] index_t;
    localparam index_t LAST_INDEX = index_t'(PIXELS - 1);

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        STREAM
    } fbState_t;

    fbState_t          state;
    rasterPkg::color_t mem [PIXELS];
    index_t            sweepIdx;
    index_t            fragIdx;
    logic              loadBeat;

    assign fragIdx = index_t'(frag.pos.y * X_RESOLUTION + frag.pos.x);
    assign fbBusy  = (state != IDLE);

    // Fetch when the output slot is empty or drains this cycle
    assign loadBeat = (state == STREAM) && (!fbValid || (fbReady && !fbBeat.last));

    ////////////////////////////////////////////////////////////
    // Clear and readout FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (rst) begin
            state    <= IDLE;
            sweepIdx <= '0;
            fbValid  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    sweepIdx <= '0;
                    if (clearStart) begin
                        state <= CLEAR;
                    end else if (commitStart) begin
                        state <= STREAM;
                    end
                end
                CLEAR: begin
                    sweepIdx <= sweepIdx + 1'b1;
                    if (sweepIdx == LAST_INDEX) begin
                        state <= IDLE;
                    end
                end
                STREAM: begin
                    if (fbValid && fbReady && fbBeat.last) begin
                        fbValid <= 1'b0;
                        state   <= IDLE;
                    end else if (loadBeat) begin
                        fbValid  <= 1'b1;
                        sweepIdx <= sweepIdx + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Color memory, single write port and registered read
    always_ff @(posedge aclk) begin
        if (state == CLEAR) begin
            mem[sweepIdx] <= clearColor;
        end else if (fragValid) begin
            mem[fragIdx] <= frag.color;
        end
        if (loadBeat) begin
            fbBeat.data <= mem[sweepIdx];
            fbBeat.last <= (sweepIdx == LAST_INDEX);
        end
    end

    // Parser holds commands back, so fragments only land while idle
    assert property (@(posedge aclk) disable iff (rst)
        fragValid |-> (state == IDLE))
        else $error("Fragment write during clear or readout");

endmodule

// File: verilog/Rasterix.sv
`timescale 1ns/1ps

module Rasterix #(
    parameter int X_RESOLUTION = 16,
    parameter int Y_RESOLUTION = 16
) (
    input  logic                   aclk,
    input  logic                   rst,

    input  logic                   cmdValid,
    output logic                   cmdReady,
    input  rasterPkg::streamBeat_t cmdBeat,

    output logic                   fbValid,
    input  logic                   fbReady,
    output rasterPkg::streamBeat_t fbBeat
);

    ////////////////////////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////////////////////////
    logic                       paramValid;
    logic                       paramReady;
    rasterPkg::streamBeat_t     paramBeat;
    logic                       bankFull;
    rasterPkg::triangleParams_t params;

    logic                       startRendering;
    logic                       rasterizerRunning;
    logic                       fragValid;
    rasterPkg::fragment_t       frag;

    logic                       clearStart;
    rasterPkg::color_t          clearColor;
    logic                       commitStart;
    logic                       fbBusy;

    CommandParser commandParser (
        .aclk(aclk), .rst(rst),
        .cmdValid(cmdValid), .cmdReady(cmdReady), .cmdBeat(cmdBeat),
        .paramValid(paramValid), .paramReady(paramReady), .paramBeat(paramBeat),
        .bankFull(bankFull),
        .startRendering(startRendering), .rasterizerRunning(rasterizerRunning),
        .clearStart(clearStart), .clearColor(clearColor),
        .commitStart(commitStart), .fbBusy(fbBusy)
    );

    RegisterBank regBank (
        .aclk(aclk), .rst(rst),
        .paramValid(paramValid), .paramReady(paramReady), .paramBeat(paramBeat),
        .params(params), .bankFull(bankFull)
    );

    Rasterizer #(
        .X_RESOLUTION(X_RESOLUTION),
        .Y_RESOLUTION(Y_RESOLUTION)
    ) rop (
        .aclk(aclk), .rst(rst),
        .startRendering(startRendering), .rasterizerRunning(rasterizerRunning),
        .params(params),
        .fragValid(fragValid), .frag(frag)
    );

    FrameBuffer #(
        .X_RESOLUTION(X_RESOLUTION),
        .Y_RESOLUTION(Y_RESOLUTION)
    ) colorBuffer (
        .aclk(aclk), .rst(rst),
        .fragValid(fragValid), .frag(frag),
        .clearStart(clearStart), .clearColor(clearColor),
        .commitStart(commitStart), .fbBusy(fbBusy),
        .fbValid(fbValid), .fbReady(fbReady), .fbBeat(fbBeat)
    );

endmodule

// File: verification/rasterixTests.svh
`ifndef RASTERIX_TESTS_SVH
`define RASTERIX_TESTS_SVH

function automatic rasterPkg::cmdWord_t headerWord(input rasterPkg::opcode_t op);
    return {op, 12'h000};
endfunction

task automatic sendClear(input rasterPkg::color_t color);
    sendWord(headerWord(rasterPkg::OP_CLEAR), 1'b0);
    sendWord(color, 1'b1);
    modelClear(color);
endtask

// Header, then the twelve words in field order
task automatic sendTriangle(input rasterPkg::triangleParams_t p);
    sendWord(headerWord(rasterPkg::OP_TRIANGLE), 1'b0);
    sendWord(p.bbStart, 1'b0);
    sendWord(p.bbEnd, 1'b0);
    sendWord(p.w0, 1'b0);
    sendWord(p.w1, 1'b0);
    sendWord(p.w2, 1'b0);
    sendWord(p.w0IncX, 1'b0);
    sendWord(p.w1IncX, 1'b0);
    sendWord(p.w2IncX, 1'b0);
    sendWord(p.w0IncY, 1'b0);
    sendWord(p.w1IncY, 1'b0);
    sendWord(p.w2IncY, 1'b0);
    sendWord(p.staticColor, 1'b1);
    modelTriangle(p);
endtask

task automatic checkResetAndNop();
    assert (cmdReady === 1'b1) else begin
        mismatchCount++;
        $display("Mismatch at %0t: cmdReady got %b expected 1", $time, cmdReady);
    end
    assert (fbValid === 1'b0) else begin
        mismatchCount++;
        $display("Mismatch at %0t: fbValid got %b expected 0", $time, fbValid);
    end
    sendClear(rasterPkg::color_t'(nextRandom()));
    sendWord(headerWord(rasterPkg::OP_NOP), 1'b1);
    // Opcode 0xF is not defined
    sendWord(16'hF5A5, 1'b1);
    sendWord(headerWord(rasterPkg::OP_COMMIT), 1'b1);
    readFrame(1'b0);
endtask

task automatic clearAndCommit();
    sendClear(rasterPkg::color_t'(nextRandom()));
    sendWord(headerWord(rasterPkg::OP_COMMIT), 1'b1);
    readFrame(1'b0);
endtask

// Legs on x = 2 and y = 2, hypotenuse x + y = 14
task automatic drawRightTriangle();
    rasterPkg::triangleParams_t triangle;
    triangle.bbStart = '{x: 8'd2, y: 8'd2};
    triangle.bbEnd   = '{x: 8'd12, y: 8'd12};
    triangle.w0 = 0;
    triangle.w1 = 0;
    triangle.w2 = 10;
    triangle.w0IncX = 1;
    triangle.w1IncX = 0;
    triangle.w2IncX = -1;
    triangle.w0IncY = 0;
    triangle.w1IncY = 1;
    triangle.w2IncY = -1;
    triangle.staticColor = rasterPkg::color_t'(nextRandom());
    sendTriangle(triangle);
    sendWord(headerWord(rasterPkg::OP_COMMIT), 1'b1);
    readFrame(1'b0);
endtask

task automatic drawOverlapAndHidden();
    rasterPkg::triangleParams_t triangle;
    // x >= 6, y <= 13, x - y >= 2
    triangle.bbStart = '{x: 8'd6, y: 8'd4};
    triangle.bbEnd   = '{x: 8'd15, y: 8'd13};
    triangle.w0 = 0;
    triangle.w1 = 9;
    triangle.w2 = 0;
    triangle.w0IncX = 1;
    triangle.w1IncX = 0;
    triangle.w2IncX = 1;
    triangle.w0IncY = 0;
    triangle.w1IncY = -1;
    triangle.w2IncY = -1;
    triangle.staticColor = rasterPkg::color_t'(nextRandom());
    sendTriangle(triangle);
    // Every edge negative everywhere, nothing drawn
    triangle.bbStart = '{x: 8'd0, y: 8'd0};
    triangle.bbEnd   = '{x: 8'd3, y: 8'd3};
    triangle.w0 = -1;
    triangle.w1 = -1;
    triangle.w2 = -1;
    triangle.w0IncX = 0;
    triangle.w1IncX = 0;
    triangle.w2IncX = 0;
    triangle.w0IncY = 0;
    triangle.w1IncY = 0;
    triangle.w2IncY = 0;
    triangle.staticColor = rasterPkg::color_t'(nextRandom());
    sendTriangle(triangle);
    sendWord(headerWord(rasterPkg::OP_COMMIT), 1'b1);
    readFrame(1'b0);
endtask

task automatic commitUnderBackPressure();
    int acceptCycle;
    sendWord(headerWord(rasterPkg::OP_COMMIT), 1'b1);
    fork
        readFrame(1'b1);
        begin
            sendWord(headerWord(rasterPkg::OP_NOP), 1'b1);
            acceptCycle = cycleCount;
        end
    join
    assert (acceptCycle > lastBeatCycle) else begin
        failureCount++;
        $display("Command accepted at cycle %0d before the readout ended at cycle %0d",
                 acceptCycle, lastBeatCycle);
    end
endtask

`endif

// File: verification/tb_Rasterix.sv
`timescale 1ns/1ps

module tb_Rasterix;

    localparam int X_RESOLUTION = 16;
    localparam int Y_RESOLUTION = 16;
    localparam int PIXELS = X_RESOLUTION * Y_RESOLUTION;
    // Five commits, one at half rate, plus clears and walks
    localparam int TIMEOUT_CYCLES = 20000;

    logic                   aclk;
    logic                   rst;
    logic                   cmdValid;
    logic                   cmdReady;
    rasterPkg::streamBeat_t cmdBeat;
    logic                   fbValid;
    logic                   fbReady;
    rasterPkg::streamBeat_t fbBeat;

    rasterPkg::color_t refImage [PIXELS];
    logic [31:0]       rngState = 32'd70118;
    int                cycleCount = 0;
    int                lastBeatCycle = 0;
    int                mismatchCount = 0;
    int                failureCount = 0;

    Rasterix #(
        .X_RESOLUTION(X_RESOLUTION),
        .Y_RESOLUTION(Y_RESOLUTION)
    ) u_Rasterix (
        .aclk(aclk), .rst(rst),
        .cmdValid(cmdValid), .cmdReady(cmdReady), .cmdBeat(cmdBeat),
        .fbValid(fbValid), .fbReady(fbReady), .fbBeat(fbBeat)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference image
    ////////////////////////////////////////////////////////////
    function automatic void modelClear(input rasterPkg::color_t color);
        for (int i = 0; i < PIXELS; i++) begin
            refImage[i] = color;
        end
    endfunction

    // Edge value at (x, y) is the start value plus dx steps of IncX and dy of IncY
    function automatic void modelTriangle(input rasterPkg::triangleParams_t p);
        int wv [3];
        int dx;
        int dy;
        for (int y = int'(p.bbStart.y); y <= int'(p.bbEnd.y); y++) begin
            for (int x = int'(p.bbStart.x); x <= int'(p.bbEnd.x); x++) begin
                dx = x - int'(p.bbStart.x);
                dy = y - int'(p.bbStart.y);
                wv[0] = int'(p.w0) + dx * int'(p.w0IncX) + dy * int'(p.w0IncY);
                wv[1] = int'(p.w1) + dx * int'(p.w1IncX) + dy * int'(p.w1IncY);
                wv[2] = int'(p.w2) + dx * int'(p.w2IncX) + dy * int'(p.w2IncY);
                // Sign of the 16 bit value
                if (!wv[0][15] && !wv[1][15] && !wv[2][15]) begin
                    refImage[y * X_RESOLUTION + x] = p.staticColor;
                end
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Stream drivers
    ////////////////////////////////////////////////////////////
    task automatic sendWord(input rasterPkg::cmdWord_t data, input logic last);
        cmdValid     <= 1'b1;
        cmdBeat.data <= data;
        cmdBeat.last <= last;
        do begin
            @(posedge aclk);
        end while (!cmdReady);
        cmdValid <= 1'b0;
    endtask

    // Collects one full frame and compares it beat by beat
    task automatic readFrame(input logic toggleReady);
        int          beatIdx;
        logic [31:0] rnd;
        beatIdx = 0;
        while (beatIdx < PIXELS) begin
            @(posedge aclk);
            if (fbValid && fbReady) begin
                assert (fbBeat.data === refImage[beatIdx]) else begin
                    mismatchCount++;
                    $display("Mismatch at %0t: fbBeat.data (beat %0d) got %h expected %h",
                             $time, beatIdx, fbBeat.data, refImage[beatIdx]);
                end
                assert (fbBeat.last === (beatIdx == PIXELS - 1)) else begin
                    mismatchCount++;
                    $display("Mismatch at %0t: fbBeat.last (beat %0d) got %b expected %b",
                             $time, beatIdx, fbBeat.last, beatIdx == PIXELS - 1);
                end
                lastBeatCycle = cycleCount;
                beatIdx++;
            end
            rnd = nextRandom();
            fbReady <= toggleReady ? rnd[0] : 1'b1;
        end
        fbReady <= 1'b1;
        @(posedge aclk);
        assert (!fbValid) else begin
            failureCount++;
            $display("Frame stream delivered more than %0d beats", PIXELS);
        end
    endtask

    `include "rasterixTests.svh"

    initial begin
        rst      = 1'b1;
        cmdValid = 1'b0;
        cmdBeat  = '0;
        fbReady  = 1'b1;
        repeat (16) @(posedge aclk);
        rst <= 1'b0;
        @(posedge aclk);
        checkResetAndNop();
        clearAndCommit();
        drawRightTriangle();
        drawOverlapAndHidden();
        commitUnderBackPressure();
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
        if (mismatchCount == 0 && failureCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(negedge aclk);
            cycleCount++;
        end
        failureCount++;
        $display("Timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: sim.f
+incdir+verification
common/rasterPkg.sv
verilog/RegisterBank.sv
commandParser/CommandParser.sv
rasterizer/Rasterizer.sv
frameBuffer/FrameBuffer.sv
verilog/Rasterix.sv
verification/tb_Rasterix.sv

// File: Bender.yml
package:
  name: rasterix

sources:
  - common/rasterPkg.sv
  - verilog/RegisterBank.sv
  - commandParser/CommandParser.sv
  - rasterizer/Rasterizer.sv
  - frameBuffer/FrameBuffer.sv
  - verilog/Rasterix.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_Rasterix.sv
